// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= gbCoreTb
OBJ_DIR ?= obj_dir
LOG ?= sim.log
GOLDEN ?= bench/gbCoreGolden.mem
VFLAGS ?= --binary --timing --assert -Wno-fatal
SIMFLAGS ?= +verilator+error+limit+100

SRCS := $(shell grep -v '^+' vlog.f)
SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): vlog.f $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f vlog.f

run: $(SIM) $(GOLDEN)
	./$(SIM) $(SIMFLAGS) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/gbCoreGolden.mem ====
# M addr bytes   program image placed from addr on
# W addr bytes   expected writes in order, J from to   taken jump, N count   instructions, hex
M 0000 26 C0 2E 00 3E 3A 06 C6
M 0008 80 77 3E 05 88 77 2C 0E
M 0010 10 91 77 D6 C0 99 77 E6
M 0018 0F 77 EE FF B1 77 3E 0F
M 0020 3C 77 3D 77 FE 0F CA 2D
M 0028 00 3E AA 77 00 FE 20 D2
M 0030 00 00 3E 11 77 2C DA 3D
M 0038 00 3E BB 77 76 3E 22 77
M 0040 FE 22 C2 39 00 3E 33 77
M 0048 50 7A 77 71 C3 60 00 76
M 0060 3E 44 77 76
W C000 00 CC
W C001 BC EB 0B F4 10 0F 11
W C002 22 33 C6 10 44
J 0028 002D
J 0038 003D
J 004E 0060
N 0030

// ==== bench/gbCoreTb.sv ====
`timescale 1ns/10ps
`default_nettype none

module gbCoreTb import cpuPkg::*;
  ();

  localparam int timeoutCycles = 2000;
  localparam int quietCycles = 100;

  logic iClock;
  logic rstN;
  byteT memData;
  addrT memAddr;
  logic memRead;
  logic memWrite;
  byteT memWData;
  logic insnDone;

  byteT mem [65536];
  addrT expWAddr [$];
  byteT expWData [$];
  addrT jumpTo [addrT];   // last byte of a taken jump to its target
  int expInsns;
  int doneCount;
  int readCount;
  int writeCount;
  int valueErrs;
  int otherErrs;
  int chkErrs;
  logic readSeen;
  logic pendRead;
  addrT pendAddr;
  addrT lastRead;

  gbCore #(.resetVector(16'h0000)) dut0 (
    .iClock(iClock),
    .rstN(rstN),
    .memData(memData),
    .memAddr(memAddr),
    .memRead(memRead),
    .memWrite(memWrite),
    .memWData(memWData),
    .insnDone(insnDone)
  );

  always #10 iClock = ~iClock;

  // ----------------------------------------
  // Memory model and bus monitor
  always @(posedge iClock)
  begin
    pendRead = memRead;
    pendAddr = memAddr;
    if (memRead)
      verifyFetch(memAddr);
    if (memWrite)
      compareWrite(memAddr, memWData);
    if (insnDone)
      doneCount++;
  end

  always @(negedge iClock)
  begin
    if (pendRead)
      memData = mem[pendAddr]; // valid in the cycle after memRead
  end

  task automatic fillMemory();
    for (int i = 0; i < 65536; i++)
      mem[i] = byteT'((i >> 8) ^ i ^ 8'hA5);
  endtask

  task automatic loadGolden();
    int fd;
    int n;
    string line;
    byte tag;
    addrT addr;
    byteT val;
    fd = $fopen("bench/gbCoreGolden.mem", "r");
    assert (fd != 0)
    else
    begin
      otherErrs++;
      $display("Could not open the golden file bench/gbCoreGolden.mem");
    end
    while (fd != 0 && !$feof(fd))
    begin
      n = $fgets(line, fd);
      if (n > 0 && line.len() >= 6)
      begin
        tag = line.getc(0);
        addr = addrT'(line.substr(2, 5).atohex());
        case (tag)
          "N": expInsns = int'(addr);
          "J": jumpTo[addr] = addrT'(line.substr(7, 10).atohex());
          "M", "W":
            for (int i = 0; 8 + 3 * i < line.len(); i++)
            begin
              val = byteT'(line.substr(7 + 3 * i, 8 + 3 * i).atohex());
              if (tag == "M")
                mem[addr + addrT'(i)] = val;
              else
              begin
                expWAddr.push_back(addr);
                expWData.push_back(val);
              end
            end
          default: ; // comment line
        endcase
      end
    end
    if (fd != 0)
      $fclose(fd);
    assert (expInsns > 0)
    else
    begin
      otherErrs++;
      $display("The golden file holds no instruction count");
    end
  endtask

  task automatic verifyFetch(input addrT addr);
    addrT want;
    if (!readSeen)
      want = 16'h0000;
    else if (jumpTo.exists(lastRead))
      want = jumpTo[lastRead];
    else
      want = lastRead + 16'd1;
    assert (addr == want)
    else
    begin
      valueErrs++;
      $display("** Error %0t: read from %h, expected %h", $time, addr, want);
    end
    readSeen = 1'b1;
    lastRead = want;
    readCount++;
  endtask

  task automatic compareWrite(input addrT addr, input byteT data);
    addrT wantAddr;
    byteT wantData;
    writeCount++;
    assert (expWAddr.size() != 0)
    else
    begin
      otherErrs++;
      $display("Unexpected write of %h to %h at %0t after all expected writes", data, addr,
               $time);
    end
    if (expWAddr.size() != 0)
    begin
      wantAddr = expWAddr.pop_front();
      wantData = expWData.pop_front();
      assert (addr == wantAddr && data == wantData)
      else
      begin
        valueErrs++;
        $display("** Error %0t: write %h to %h, expected %h to %h", $time, data, addr,
                 wantData, wantAddr);
      end
    end
    mem[addr] = data;
  endtask

  task automatic waitInsns(input int count);
    int cycles;
    cycles = 0;
    while (doneCount < count && cycles < timeoutCycles)
    begin
      @(negedge iClock);
      cycles++;
    end
    assert (doneCount >= count)
    else
    begin
      otherErrs++;
      $display("Timed out after %0d cycles with %0d of %0d instructions done", cycles,
               doneCount, count);
    end
  endtask

  // Nothing may move on the bus once HALT has executed
  task automatic watchHalt();
    int done0;
    int reads0;
    int writes0;
    done0 = doneCount;
    reads0 = readCount;
    writes0 = writeCount;
    repeat (quietCycles) @(negedge iClock);
    assert (doneCount == done0 && readCount == reads0 && writeCount == writes0)
    else
    begin
      otherErrs++;
      $display("Strobes still seen in the %0d cycles after HALT", quietCycles);
    end
  endtask

  // ----------------------------------------
  initial
  begin
    iClock = 1'b0;
    rstN = 1'b0;
    memData = 8'h00;
    expInsns = 0;
    doneCount = 0;
    readCount = 0;
    writeCount = 0;
    valueErrs = 0;
    otherErrs = 0;
    readSeen = 1'b0;
    pendRead = 1'b0;
    pendAddr = 16'h0000;
    lastRead = 16'h0000;
    fillMemory();
    loadGolden();
    repeat (3) @(negedge iClock);
    rstN = 1'b1;

    waitInsns(expInsns);
    watchHalt();

    assert (doneCount == expInsns)
    else
    begin
      valueErrs++;
      $display("** Error %0t: %0d instructions done, expected %0d", $time, doneCount,
               expInsns);
    end
    assert (expWAddr.size() == 0)
    else
    begin
      otherErrs++;
      $display("%0d expected writes never happened", expWAddr.size());
    end

    chkErrs = dut0.chk0.assertFails;
    $display("Error counts %0d value, %0d other, %0d protocol", valueErrs, otherErrs, chkErrs);
    if (valueErrs + otherErrs + chkErrs == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/gbCore_chk.sv ====
`timescale 1ns/10ps
`default_nettype none

module gbCoreChk
(
  input logic iClock,
  input logic rstN,
  input logic memRead,
  input logic memWrite,
  input logic insnDone
);

  int assertFails = 0;

  // ----------------------------------------
  // Bus and strobe protocol
  oneStrobe: assert property (@(posedge iClock) disable iff (!rstN) !(memRead && memWrite))
  else
  begin
    $error("memRead and memWrite high in the same cycle");
    assertFails++;
  end

  singleDone: assert property (@(posedge iClock) disable iff (!rstN) insnDone |=> !insnDone)
  else
  begin
    $error("insnDone high two cycles running");
    assertFails++;
  end

  // Async reset clears all strobes
  quietReset: assert property (@(posedge iClock) !rstN |-> !(memRead || memWrite || insnDone))
  else
  begin
    $error("Strobe high while rstN is low");
    assertFails++;
  end

endmodule

bind gbCore gbCoreChk chk0 (.*);

`default_nettype wire

// ==== hw/busPort.sv ====
`timescale 1ns/10ps
`default_nettype none

module busPort import cpuPkg::*;
(
  input  logic iClock,
  input  logic rstN,
  input  logic readReq,
  input  addrT pc,
  input  logic writeReq,
  input  addrT hlAddr,
  input  byteT storeData,
  output addrT memAddr,
  output logic memRead,
  output logic memWrite,
  output byteT memWData,
  output logic readIssued
);

  logic readHeld;  // read lost to a write last cycle
  logic readNow;

  assign readNow = readReq | readHeld;
  assign readIssued = memRead;

  // ----------------------------------------
  // Strobes, write wins a collision
  always_ff @(posedge iClock or negedge rstN)
  begin
    if (!rstN)
    begin
      memRead <= 1'b0;
      memWrite <= 1'b0;
      readHeld <= 1'b0;
    end
    else
    begin
      memWrite <= writeReq;
      memRead <= readNow & ~writeReq;
      readHeld <= readNow & writeReq;
    end
  end

  always_ff @(posedge iClock)
  begin
    if (writeReq)
    begin
      memAddr <= hlAddr;
      memWData <= storeData;
    end
    else if (readNow)
      memAddr <= pc; // PC is stable while a read is held
  end

endmodule

`default_nettype wire

// ==== hw/cpuPkg.sv ====
`default_nettype none

package cpuPkg;

  // Datapath widths
  typedef logic [7:0]  byteT;
  typedef logic [15:0] addrT;   // also the program counter
  typedef logic [2:0]  regIdxT; // B C D E H L (HL) A
  typedef logic [7:0]  flagsT;

  // ----------------------------------------
  // Flag byte layout, low nibble reads zero
  localparam int flagZ = 7;
  localparam int flagN = 6;
  localparam int flagH = 5;
  localparam int flagC = 4;

  localparam flagsT flagsReset = 8'hB0;

endpackage

`default_nettype wire

// ==== hw/execCtrlIf.sv ====
`timescale 1ns/10ps
`default_nettype none

interface execCtrlIf import cpuPkg::*, isaPkg::*;
  ();

  logic   issue;      // one-cycle strobe
  aluOpT  aluOp;
  regIdxT dst;
  regIdxT src;
  logic   useImm;
  byteT   imm;
  logic   writeReg;
  logic   writeFlags;
  logic   store;

  modport fetch (output issue, aluOp, dst, src, useImm, imm, writeReg, writeFlags, store);
  modport exec  (input  issue, aluOp, dst, src, useImm, imm, writeReg, writeFlags, store);

endinterface

`default_nettype wire

// ==== hw/execUnit.sv ====
`timescale 1ns/10ps
`default_nettype none

module execUnit import cpuPkg::*, isaPkg::*;
(
  input  logic iClock,
  input  logic rstN,
  execCtrlIf.exec ctrl,
  output flagsT flags,
  output logic writeReq,
  output addrT hlAddr,
  output byteT storeData
);

  byteT regFile [8]; // slot 6 is (HL), never written
  byteT acc;
  byteT opnd;
  byteT result;
  flagsT newFlags;
  logic carryIn;
  logic [8:0] sum9;
  logic [8:0] diff9;
  logic [4:0] halfSum;
  logic [4:0] halfDiff;

  assign acc = regFile[regA];
  assign opnd = ctrl.useImm ? ctrl.imm : regFile[ctrl.src];
  assign carryIn = (ctrl.aluOp == aluAdc || ctrl.aluOp == aluSbc) ? flags[flagC] : 1'b0;

  assign sum9 = {1'b0, acc} + {1'b0, opnd} + {8'd0, carryIn};
  assign diff9 = {1'b0, acc} - {1'b0, opnd} - {8'd0, carryIn};
  assign halfSum = {1'b0, acc[3:0]} + {1'b0, opnd[3:0]} + {4'd0, carryIn};
  assign halfDiff = {1'b0, acc[3:0]} - {1'b0, opnd[3:0]} - {4'd0, carryIn};

  // ----------------------------------------
  // ALU and flag rules
  always_comb
  begin
    result = opnd;
    newFlags = flags;
    case (ctrl.aluOp)
      aluAdd, aluAdc:
      begin
        result = sum9[7:0];
        newFlags[flagN] = 1'b0;
        newFlags[flagH] = halfSum[4];
        newFlags[flagC] = sum9[8];
      end
      aluSub, aluSbc, aluCp:
      begin
        result = diff9[7:0];
        newFlags[flagN] = 1'b1;
        newFlags[flagH] = halfDiff[4]; // borrow from bit 4
        newFlags[flagC] = diff9[8];
      end
      aluAnd:
      begin
        result = acc & opnd;
        newFlags[flagN] = 1'b0;
        newFlags[flagH] = 1'b1;
        newFlags[flagC] = 1'b0;
      end
      aluXor, aluOr:
      begin
        result = (ctrl.aluOp == aluXor) ? (acc ^ opnd) : (acc | opnd);
        newFlags[flagN] = 1'b0;
        newFlags[flagH] = 1'b0;
        newFlags[flagC] = 1'b0;
      end
      aluInc:
      begin
        result = opnd + 8'd1;
        newFlags[flagN] = 1'b0;
        newFlags[flagH] = (opnd[3:0] == 4'hF);
      end
      aluDec:
      begin
        result = opnd - 8'd1;
        newFlags[flagN] = 1'b1;
        newFlags[flagH] = (opnd[3:0] == 4'h0);
      end
      default: result = opnd; // plain load
    endcase
    newFlags[flagZ] = (result == 8'd0);
    newFlags[3:0] = 4'd0;
  end

  // Registers and flags
  always_ff @(posedge iClock or negedge rstN)
  begin
    if (!rstN)
    begin
      for (int i = 0; i < 8; i++)
        regFile[i] <= 8'd0;
      flags <= flagsReset;
    end
    else if (ctrl.issue)
    begin
      if (ctrl.writeReg && ctrl.aluOp != aluCp)
        regFile[ctrl.dst] <= result;
      if (ctrl.writeFlags)
        flags <= newFlags;
    end
  end

  // ----------------------------------------
  // Store request, bus port registers it
  assign writeReq = ctrl.issue & ctrl.store;
  assign hlAddr = {regFile[regH], regFile[regL]};
  assign storeData = regFile[ctrl.src];

endmodule

`default_nettype wire

// ==== hw/gbCore.sv ====
`timescale 1ns/10ps
`default_nettype none

module gbCore import cpuPkg::*;
#(
  parameter addrT resetVector = 16'h0100
)
(
  input  logic iClock,
  input  logic rstN,
  input  byteT memData,
  output addrT memAddr,
  output logic memRead,
  output logic memWrite,
  output byteT memWData,
  output logic insnDone
);

  flagsT flags;
  logic readReq;
  logic readIssued;
  logic writeReq;
  addrT pc;
  addrT hlAddr;
  byteT storeData;

  execCtrlIf ctrlBus ();

  // ----------------------------------------
  insnFetch #(.resetVector(resetVector)) fetch0 (
    .iClock(iClock),
    .rstN(rstN),
    .memData(memData),
    .flags(flags),
    .readIssued(readIssued),
    .ctrl(ctrlBus.fetch),
    .readReq(readReq),
    .pc(pc),
    .insnDone(insnDone)
  );

  execUnit exec0 (
    .iClock(iClock),
    .rstN(rstN),
    .ctrl(ctrlBus.exec),
    .flags(flags),
    .writeReq(writeReq),
    .hlAddr(hlAddr),
    .storeData(storeData)
  );

  busPort bus0 (
    .iClock(iClock),
    .rstN(rstN),
    .readReq(readReq),
    .pc(pc),
    .writeReq(writeReq),
    .hlAddr(hlAddr),
    .storeData(storeData),
    .memAddr(memAddr),
    .memRead(memRead),
    .memWrite(memWrite),
    .memWData(memWData),
    .readIssued(readIssued)
  );

endmodule

`default_nettype wire

// ==== hw/insnFetch.sv ====
`timescale 1ns/10ps
`default_nettype none

module insnFetch import cpuPkg::*, isaPkg::*;
#(
  parameter addrT resetVector = 16'h0100
)
(
  input  logic iClock,
  input  logic rstN,
  input  byteT memData,
  input  flagsT flags,
  input  logic readIssued,
  execCtrlIf.fetch ctrl,
  output logic readReq,
  output addrT pc,
  output logic insnDone
);

  typedef enum logic [2:0] {
    fetchReq, fetchWait, fetchCapture, immReq, immWait, immCapture, execute, halted
  } fetchStateT;

  fetchStateT state;
  byteT opcode;
  byteT decOp;
  byteT immLo;
  byteT immHi;
  logic [1:0] immLeft;
  logic [1:0] immNeeded;
  logic isJump;
  logic isHalt;
  logic condMet;
  condT cond;

  // Opcode arrives straight from the bus in the capture cycle
  assign decOp = (state == fetchCapture) ? memData : opcode;

  // ----------------------------------------
  // Decode
  always_comb
  begin
    ctrl.aluOp = aluPass;
    ctrl.dst = decOp[fieldDst +: 3];
    ctrl.src = decOp[fieldSrc +: 3];
    ctrl.useImm = 1'b0;
    ctrl.writeReg = 1'b0;
    ctrl.writeFlags = 1'b0;
    ctrl.store = 1'b0;
    immNeeded = 2'd0;
    isJump = 1'b0;
    isHalt = 1'b0;
    cond = condNone;
    if (decOp == opHalt)
      isHalt = 1'b1;
    else if (decOp == opJp || decOp == opJpNz || decOp == opJpZ || decOp == opJpNc ||
             decOp == opJpC)
    begin
      isJump = 1'b1;
      immNeeded = 2'd2;
      case (decOp)
        opJpNz: cond = condNz;
        opJpZ: cond = condZ;
        opJpNc: cond = condNc;
        opJpC: cond = condC;
        default: cond = condNone;
      endcase
    end
    else if ((decOp & ldRrMask) == ldRrMatch)
    begin
      // LD (HL),r is a store, LD r,(HL) is not supported
      if (ctrl.dst == regHl && ctrl.src != regHl)
        ctrl.store = 1'b1;
      else if (ctrl.dst != regHl && ctrl.src != regHl)
        ctrl.writeReg = 1'b1;
    end
    else if ((decOp & ldRnMask) == ldRnMatch && ctrl.dst != regHl)
    begin
      ctrl.useImm = 1'b1;
      ctrl.writeReg = 1'b1;
      immNeeded = 2'd1;
    end
    else if (((decOp & aluRMask) == aluRMatch && ctrl.src != regHl) ||
             (decOp & aluNMask) == aluNMatch)
    begin
      ctrl.aluOp = aluOpT'({1'b0, decOp[fieldDst +: 3]});
      ctrl.dst = regA;
      ctrl.writeReg = 1'b1; // CP is filtered in the execute unit
      ctrl.writeFlags = 1'b1;
      if ((decOp & aluNMask) == aluNMatch)
      begin
        ctrl.useImm = 1'b1;
        immNeeded = 2'd1;
      end
    end
    else if (((decOp & incMask) == incMatch || (decOp & decMask) == decMatch) &&
             ctrl.dst != regHl)
    begin
      ctrl.aluOp = ((decOp & incMask) == incMatch) ? aluInc : aluDec;
      ctrl.src = ctrl.dst;
      ctrl.writeReg = 1'b1;
      ctrl.writeFlags = 1'b1;
    end
  end

  always_comb
  begin
    case (cond)
      condNz: condMet = ~flags[flagZ];
      condZ: condMet = flags[flagZ];
      condNc: condMet = ~flags[flagC];
      condC: condMet = flags[flagC];
      default: condMet = 1'b1;
    endcase
  end

  assign ctrl.imm = immLo;
  assign ctrl.issue = (state == execute);
  assign insnDone = (state == execute);
  assign readReq = (state == fetchReq) || (state == immReq);

  // ----------------------------------------
  // Fetch FSM and program counter
  always_ff @(posedge iClock or negedge rstN)
  begin
    if (!rstN)
    begin
      state <= fetchReq;
      pc <= resetVector;
      immLeft <= 2'd0;
    end
    else
    begin
      case (state)
        fetchReq: state <= fetchWait;
        fetchWait: if (readIssued) state <= fetchCapture; // a store may hold the read
        fetchCapture:
        begin
          pc <= pc + 16'd1;
          immLeft <= immNeeded;
          state <= (immNeeded != 2'd0) ? immReq : execute;
        end
        immReq: state <= immWait;
        immWait: if (readIssued) state <= immCapture;
        immCapture:
        begin
          pc <= pc + 16'd1;
          immLeft <= immLeft - 2'd1;
          state <= (immLeft == 2'd1) ? execute : immReq;
        end
        execute:
        begin
          if (isJump && condMet)
            pc <= {immHi, immLo};
          state <= isHalt ? halted : fetchReq;
        end
        default: state <= halted; // only reset leaves
      endcase
    end
  end

  always_ff @(posedge iClock)
  begin
    if (state == fetchCapture)
      opcode <= memData;
    if (state == immCapture)
    begin
      if (immLeft == immNeeded)
        immLo <= memData; // low byte first
      else
        immHi <= memData;
    end
  end

endmodule

`default_nettype wire

// ==== hw/isaPkg.sv ====
`default_nettype none

package isaPkg;

  // Low three codes follow the opcode ALU field
  typedef enum logic [3:0] {
    aluAdd  = 4'd0,
    aluAdc  = 4'd1,
    aluSub  = 4'd2,
    aluSbc  = 4'd3,
    aluAnd  = 4'd4,
    aluXor  = 4'd5,
    aluOr   = 4'd6,
    aluCp   = 4'd7,
    aluInc  = 4'd8,
    aluDec  = 4'd9,
    aluPass = 4'd10
  } aluOpT;

  typedef enum logic [2:0] {condNone, condNz, condZ, condNc, condC} condT;

  // Opcode bit fields
  localparam int fieldDst = 3; // bits 5:3, also ALU op
  localparam int fieldSrc = 0; // bits 2:0

  localparam logic [7:0] opNop  = 8'h00;
  localparam logic [7:0] opHalt = 8'h76;
  localparam logic [7:0] opJp   = 8'hC3;
  localparam logic [7:0] opJpNz = 8'hC2;
  localparam logic [7:0] opJpZ  = 8'hCA;
  localparam logic [7:0] opJpNc = 8'hD2;
  localparam logic [7:0] opJpC  = 8'hDA;

  // ----------------------------------------
  // Group masks, match when (op & mask) == value
  localparam logic [7:0] ldRrMask  = 8'hC0, ldRrMatch  = 8'h40;
  localparam logic [7:0] ldRnMask  = 8'hC7, ldRnMatch  = 8'h06;
  localparam logic [7:0] aluRMask  = 8'hC0, aluRMatch  = 8'h80;
  localparam logic [7:0] aluNMask  = 8'hC7, aluNMatch  = 8'hC6;
  localparam logic [7:0] incMask   = 8'hC7, incMatch   = 8'h04;
  localparam logic [7:0] decMask   = 8'hC7, decMatch   = 8'h05;

  localparam logic [2:0] regH  = 3'd4;
  localparam logic [2:0] regL  = 3'd5;
  localparam logic [2:0] regHl = 3'd6; // memory operand
  localparam logic [2:0] regA  = 3'd7;

endpackage

`default_nettype wire

// ==== vlog.f ====
hw/cpuPkg.sv
hw/isaPkg.sv
hw/execCtrlIf.sv
hw/insnFetch.sv
hw/execUnit.sv
hw/busPort.sv
hw/gbCore.sv
bench/gbCore_chk.sv
bench/gbCoreTb.sv
